/* mips_params.svh */
`ifndef mipsParamsSvh
`define mipsParamsSvh

////////////////////////////////////////////////////////////////////////////
// Primary opcodes
////////////////////////////////////////////////////////////////////////////
`define OpSpecial   6'b000000
`define OpOri       6'b001101
`define OpLui       6'b001111
`define OpLw        6'b100011
`define OpSw        6'b101011
`define OpBeq       6'b000100
`define OpJal       6'b000011
`define OpBne       6'b000101
`define OpAddi      6'b001000
`define OpAndi      6'b001100
`define OpLb        6'b100000
`define OpLh        6'b100001
`define OpSb        6'b101000
`define OpSh        6'b101001
`define OpCop0      6'b010000

// SPECIAL funct codes
`define FnAdd       6'b100000
`define FnSub       6'b100010
`define FnJr        6'b001000
`define FnOr        6'b100101
`define FnSlt       6'b101010
`define FnSltu      6'b101011
`define FnAnd       6'b100100
`define FnMult      6'b011000
`define FnDiv       6'b011010
`define FnMultu     6'b011001
`define FnDivu      6'b011011
`define FnMfhi      6'b010000
`define FnMflo      6'b010010
`define FnMthi      6'b010001
`define FnMtlo      6'b010011
`define FnSyscall   6'b001100
`define FnEret      6'b011000

// COP0 rs field
`define RsMfc0      5'b00000
`define RsMtc0      5'b00100
`define RsEret      5'b10000

////////////////////////////////////////////////////////////////////////////
// Address map, bounds inclusive
////////////////////////////////////////////////////////////////////////////
`define RamLast     32'h0000_2FFF
`define PcFirst     32'h0000_3000
`define PcLast      32'h0000_6FFC
`define Timer0First 32'h0000_7F00
`define Timer0Last  32'h0000_7F0B
`define Timer1First 32'h0000_7F10
`define Timer1Last  32'h0000_7F1B
`define IntGenFirst 32'h0000_7F20
`define IntGenLast  32'h0000_7F23

// Cause.ExcCode values
`define ExcInt      5'd0
`define ExcAdEL     5'd4
`define ExcAdES     5'd5
`define ExcSys      5'd8
`define ExcRI       5'd10
`define ExcOv       5'd12

// CP0 register numbers
`define Cp0Sr       5'd12
`define Cp0Cause    5'd13
`define Cp0Epc      5'd14
`define Cp0Prid     5'd15

`define PRIdValue   32'h0000_3A01

`endif

/* mipsIsaPkg.sv */
`default_nettype none

package mipsIsaPkg;

	// Data word or byte address
	typedef logic [31:0] wordT;

	// Instruction fields
	typedef logic [5:0] opcodeT;
	typedef logic [5:0] functT;

	// rs, rt and rd are all this wide
	typedef logic [4:0] regAddrT;

endpackage

`default_nettype wire

/* excPkg.sv */
`default_nettype none

package excPkg;

	// ExcCode field of Cause
	typedef logic [4:0] excCodeT;

	// Hardware interrupt lines, also the IM and IP fields
	typedef logic [5:0] hwIntT;

	// CP0 register number, taken from rd
	typedef logic [4:0] cp0AddrT;

endpackage

`default_nettype wire

/* excCoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_params.svh"

module excCoder (
	input  wire mipsIsaPkg::wordT pc,
	input  wire mipsIsaPkg::wordT instr,
	input  wire mipsIsaPkg::wordT addr,
	input  wire                   aluOverflow,
	input  wire                   addrOverflow,
	input  wire                   intReq,
	output logic                  excValid,
	output logic                  isMtc0,
	output logic                  isEret,
	output excPkg::excCodeT       excCode
);

	mipsIsaPkg::opcodeT  opcode;
	mipsIsaPkg::functT   funct;
	mipsIsaPkg::regAddrT rs;

	logic add, sub, ori, lui, lw, sw, beq, jal, jr, orr, slt;
	logic sltu, bne, addi, andr, andi, lb, lh, sb, sh;
	logic mult, multu, div, divu, mfhi, mflo, mthi, mtlo;
	logic syscall, mfc0;

	logic isLoad, isStore;
	logic inRam, inTimer, inIntGen, inMap;
	logic pcFault, loadFault, storeFault;
	logic reserved, arithOv;

	assign opcode = instr[31:26];
	assign rs     = instr[25:21];
	assign funct  = instr[5:0];

	////////////////////////////////////////////////////////////////////////////
	// Instruction decode
	////////////////////////////////////////////////////////////////////////////
	assign add     = (opcode == `OpSpecial) && (funct == `FnAdd);
	assign sub     = (opcode == `OpSpecial) && (funct == `FnSub);
	assign jr      = (opcode == `OpSpecial) && (funct == `FnJr);
	assign orr     = (opcode == `OpSpecial) && (funct == `FnOr);
	assign slt     = (opcode == `OpSpecial) && (funct == `FnSlt);
	assign sltu    = (opcode == `OpSpecial) && (funct == `FnSltu);
	assign andr    = (opcode == `OpSpecial) && (funct == `FnAnd);
	assign mult    = (opcode == `OpSpecial) && (funct == `FnMult);
	assign multu   = (opcode == `OpSpecial) && (funct == `FnMultu);
	assign div     = (opcode == `OpSpecial) && (funct == `FnDiv);
	assign divu    = (opcode == `OpSpecial) && (funct == `FnDivu);
	assign mfhi    = (opcode == `OpSpecial) && (funct == `FnMfhi);
	assign mflo    = (opcode == `OpSpecial) && (funct == `FnMflo);
	assign mthi    = (opcode == `OpSpecial) && (funct == `FnMthi);
	assign mtlo    = (opcode == `OpSpecial) && (funct == `FnMtlo);
	assign syscall = (opcode == `OpSpecial) && (funct == `FnSyscall);

	assign ori  = (opcode == `OpOri);
	assign lui  = (opcode == `OpLui);
	assign lw   = (opcode == `OpLw);
	assign sw   = (opcode == `OpSw);
	assign beq  = (opcode == `OpBeq);
	assign bne  = (opcode == `OpBne);
	assign jal  = (opcode == `OpJal);
	assign addi = (opcode == `OpAddi);
	assign andi = (opcode == `OpAndi);
	assign lb   = (opcode == `OpLb);
	assign lh   = (opcode == `OpLh);
	assign sb   = (opcode == `OpSb);
	assign sh   = (opcode == `OpSh);

	// COP0 group, told apart by rs
	assign mfc0   = (opcode == `OpCop0) && (rs == `RsMfc0);
	assign isMtc0 = (opcode == `OpCop0) && (rs == `RsMtc0);
	assign isEret = (opcode == `OpCop0) && (rs == `RsEret) && (funct == `FnEret);

	// All-zero word is the nop and stays legal
	assign reserved = ~(add | sub | ori | lui | lw | sw | beq | jal | jr | orr | slt
		| sltu | bne | addi | andr | andi | lb | lh | sb | sh | mult | multu
		| div | divu | mfhi | mflo | mthi | mtlo | syscall | mfc0 | isMtc0
		| isEret | (instr == 32'b0));

	////////////////////////////////////////////////////////////////////////////
	// Address checks
	////////////////////////////////////////////////////////////////////////////
	assign isLoad  = lw | lh | lb;
	assign isStore = sw | sh | sb;

	assign inRam    = (addr <= `RamLast);
	assign inTimer  = ((addr >= `Timer0First) && (addr <= `Timer0Last))
		|| ((addr >= `Timer1First) && (addr <= `Timer1Last));
	assign inIntGen = (addr >= `IntGenFirst) && (addr <= `IntGenLast);
	assign inMap    = inRam | inTimer | inIntGen;

	// Timers take whole words only
	assign loadFault = (lw && (addr[1:0] != 2'b00))
		|| (lh && addr[0])
		|| ((lh || lb) && inTimer)
		|| (isLoad && (addrOverflow || !inMap));

	assign storeFault = (sw && (addr[1:0] != 2'b00))
		|| (sh && addr[0])
		|| ((sh || sb) && inTimer)
		|| (isStore && (addrOverflow || !inMap));

	// PC 0 is a bubble
	assign pcFault = (pc != 32'b0)
		&& ((pc[1:0] != 2'b00) || (pc < `PcFirst) || (pc > `PcLast));

	assign arithOv = (add | addi | sub) & aluOverflow;

	// Fixed priority, interrupt first
	assign excValid = intReq | pcFault | loadFault | storeFault | syscall
		| reserved | arithOv;

	assign excCode = intReq                 ? `ExcInt  :
	                 (pcFault | loadFault)  ? `ExcAdEL :
	                 storeFault             ? `ExcAdES :
	                 syscall                ? `ExcSys  :
	                 reserved               ? `ExcRI   :
	                 arithOv                ? `ExcOv   :
	                 `ExcInt;

endmodule

`default_nettype wire

/* cp0Regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_params.svh"

module cp0Regs (
	input  wire                   clk,
	input  wire                   rstN,
	input  wire                   excValid,
	input  wire                   isMtc0,
	input  wire                   isEret,
	input  wire excPkg::excCodeT  excCode,
	input  wire mipsIsaPkg::wordT pc,
	input  wire mipsIsaPkg::wordT writeData,
	input  wire excPkg::hwIntT    hwInt,
	input  wire excPkg::cp0AddrT  cp0Addr,
	output logic                  intReq,
	output logic                  excTaken,
	output mipsIsaPkg::wordT      readData,
	output mipsIsaPkg::wordT      epc
);

	// SR fields
	excPkg::hwIntT im;
	logic          exl;
	logic          ie;

	// Cause fields
	excPkg::hwIntT   ip;
	excPkg::excCodeT causeCode;

	////////////////////////////////////////////////////////////////////////////
	// Request and commit decision
	////////////////////////////////////////////////////////////////////////////
	assign intReq = (|(hwInt & im)) & ie & ~exl;

	// Nothing is taken again until eret drops EXL
	assign excTaken = excValid & ~exl;

	////////////////////////////////////////////////////////////////////////////
	// Register update
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			im        <= '0;
			exl       <= 1'b0;
			ie        <= 1'b0;
			ip        <= '0;
			causeCode <= '0;
			epc       <= '0;
		end else begin
			ip <= hwInt;
			if (excTaken) begin
				epc       <= pc;
				causeCode <= excCode;
				exl       <= 1'b1;
			end else begin
				if (isEret) begin
					exl <= 1'b0;
				end
				// Cause and PRId are read-only
				if (isMtc0) begin
					case (cp0Addr)
						`Cp0Sr: begin
							im  <= writeData[15:10];
							exl <= writeData[1];
							ie  <= writeData[0];
						end
						`Cp0Epc: begin
							epc <= writeData;
						end
						default: begin
						end
					endcase
				end
			end
		end
	end

	// mfc0 read port
	always_comb begin
		case (cp0Addr)
			`Cp0Sr:    readData = {16'b0, im, 8'b0, exl, ie};
			`Cp0Cause: readData = {16'b0, ip, 3'b0, causeCode, 2'b0};
			`Cp0Epc:   readData = epc;
			`Cp0Prid:  readData = `PRIdValue;
			default:   readData = '0;
		endcase
	end

endmodule

`default_nettype wire

/* excUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module excUnit (
	input  wire                   clk,
	input  wire                   rstN,
	input  wire mipsIsaPkg::wordT pc,
	input  wire mipsIsaPkg::wordT instr,
	input  wire mipsIsaPkg::wordT addr,
	input  wire                   aluOverflow,
	input  wire                   addrOverflow,
	input  wire excPkg::hwIntT    hwInt,
	input  wire mipsIsaPkg::wordT writeData,
	output logic                  excTaken,
	output excPkg::excCodeT       excCode,
	output mipsIsaPkg::wordT      readData,
	output mipsIsaPkg::wordT      epc
);

	logic            intReq;
	logic            excValid;
	logic            isMtc0;
	logic            isEret;
	excPkg::cp0AddrT cp0Addr;

	// CP0 register number sits in rd
	assign cp0Addr = instr[15:11];

	excCoder u0 (
		.pc(pc),
		.instr(instr),
		.addr(addr),
		.aluOverflow(aluOverflow),
		.addrOverflow(addrOverflow),
		.intReq(intReq),
		.excValid(excValid),
		.isMtc0(isMtc0),
		.isEret(isEret),
		.excCode(excCode)
	);

	cp0Regs u1 (
		.clk(clk),
		.rstN(rstN),
		.excValid(excValid),
		.isMtc0(isMtc0),
		.isEret(isEret),
		.excCode(excCode),
		.pc(pc),
		.writeData(writeData),
		.hwInt(hwInt),
		.cp0Addr(cp0Addr),
		.intReq(intReq),
		.excTaken(excTaken),
		.readData(readData),
		.epc(epc)
	);

endmodule

`default_nettype wire

/* excUnit_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module excUnitAssert (
	input wire                   clk,
	input wire                   rstN,
	input wire mipsIsaPkg::wordT pc,
	input wire                   excTaken,
	input wire mipsIsaPkg::wordT epc,
	input wire                   intReq,
	input wire                   excValid,
	input wire                   isEret
);

	// Failures seen so far, read by the testbench at the end
	int unsigned failCount = 0;

	// SR is zero in reset, so no request
	resetQuiet: assert property (@(posedge clk) !rstN |-> !intReq)
		else begin
			failCount++;
			$error("interrupt request while in reset");
		end

	epcCapture: assert property (@(posedge clk) disable iff (!rstN)
		excTaken |=> (epc == $past(pc)))
		else begin
			failCount++;
			$error("EPC does not hold the faulting PC");
		end

	// EXL set by the commit blocks the next one
	exlBlocks: assert property (@(posedge clk) disable iff (!rstN) excTaken |=> !excTaken)
		else begin
			failCount++;
			$error("exception taken twice in a row");
		end

	// EXL dropped by eret lets the next fault through
	eretReopens: assert property (@(posedge clk) disable iff (!rstN)
		(isEret && !excTaken) |=> (!excValid || excTaken))
		else begin
			failCount++;
			$error("fault after eret not taken");
		end

endmodule

bind excUnit excUnitAssert chk0 (
	.clk(clk),
	.rstN(rstN),
	.pc(pc),
	.excTaken(excTaken),
	.epc(epc),
	.intReq(intReq),
	.excValid(excValid),
	.isEret(isEret)
);

`default_nettype wire

/* tbExcUnit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_params.svh"

module tbExcUnit;

	logic             clk;
	logic             rstN;
	mipsIsaPkg::wordT pc, instr, addr, writeData;
	logic             aluOverflow, addrOverflow;
	excPkg::hwIntT    hwInt;
	logic             excTaken;
	excPkg::excCodeT  excCode;
	mipsIsaPkg::wordT readData, epc;

	// Values applied with the next step
	excPkg::hwIntT    hwNext;
	mipsIsaPkg::wordT wdNext;

	logic [31:0] lfsr;
	int          errCount, testErrs, testCount, badTests;
	string       testName;

	localparam mipsIsaPkg::wordT nop = 32'h0;
	localparam mipsIsaPkg::wordT eretWord = {`OpCop0, `RsEret, 15'd0, `FnEret};

	excUnit dut0 (
		.clk(clk),
		.rstN(rstN),
		.pc(pc),
		.instr(instr),
		.addr(addr),
		.aluOverflow(aluOverflow),
		.addrOverflow(addrOverflow),
		.hwInt(hwInt),
		.writeData(writeData),
		.excTaken(excTaken),
		.excCode(excCode),
		.readData(readData),
		.epc(epc)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] randBits(input int count);
		logic [31:0] value;
		int          i;
		value = '0;
		for (i = 0; i < count; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return value;
	endfunction

	function automatic mipsIsaPkg::wordT opWord(input mipsIsaPkg::opcodeT op);
		return {op, 26'd0};
	endfunction

	function automatic mipsIsaPkg::wordT specialWord(input mipsIsaPkg::functT fn);
		return {`OpSpecial, 20'd0, fn};
	endfunction

	function automatic mipsIsaPkg::wordT cop0Word(input mipsIsaPkg::regAddrT rsV,
			input excPkg::cp0AddrT rd);
		return {`OpCop0, rsV, 5'd0, rd, 11'd0};
	endfunction

	// Drive on the rising edge, leave at the falling edge for checks
	task automatic step(input mipsIsaPkg::wordT pcV, input mipsIsaPkg::wordT instrV,
			input mipsIsaPkg::wordT addrV, input logic aluOv, input logic addrOv);
		@(posedge clk);
		pc <= pcV;
		instr <= instrV;
		addr <= addrV;
		aluOverflow <= aluOv;
		addrOverflow <= addrOv;
		hwInt <= hwNext;
		writeData <= wdNext;
		@(negedge clk);
	endtask

	task automatic exec(input mipsIsaPkg::wordT pcV, input mipsIsaPkg::wordT instrV);
		step(pcV, instrV, 32'h0, 1'b0, 1'b0);
	endtask

	task automatic checkWord(input string name, input mipsIsaPkg::wordT got,
			input mipsIsaPkg::wordT exp);
		assert (got === exp) else begin
			$display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
			errCount++;
		end
	endtask

	task automatic checkExc(input string name, input logic takenExp,
			input excPkg::excCodeT codeExp);
		assert (excTaken === takenExp) else begin
			$display("MISMATCH t=%0t %s excTaken got %b expected %b", $time, name,
				excTaken, takenExp);
			errCount++;
		end
		if (takenExp) begin
			assert (excCode === codeExp) else begin
				$display("MISMATCH t=%0t %s excCode got %0d expected %0d", $time, name,
					excCode, codeExp);
				errCount++;
			end
		end
	endtask

	task automatic noExc(input string name);
		checkExc(name, 1'b0, `ExcInt);
	endtask

	// One fault, then eret so the next fault is taken
	task automatic faultCase(input string name, input mipsIsaPkg::wordT pcV,
			input mipsIsaPkg::wordT instrV, input mipsIsaPkg::wordT addrV,
			input logic aluOv, input logic addrOv, input excPkg::excCodeT code);
		step(pcV, instrV, addrV, aluOv, addrOv);
		checkExc(name, 1'b1, code);
		exec(`PcFirst, eretWord);
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrs = errCount;
	endtask

	task automatic endTest();
		testCount++;
		if (errCount == testErrs) begin
			$display("test %-20s ok", testName);
		end else begin
			badTests++;
			$display("test %-20s %0d errors", testName, errCount - testErrs);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		int               k;
		mipsIsaPkg::wordT ramAddr;
		mipsIsaPkg::wordT expWord;
		lfsr = 32'hbcdd_351b;
		rstN = 1'b0;
		pc = '0;
		instr = '0;
		addr = '0;
		writeData = '0;
		aluOverflow = 1'b0;
		addrOverflow = 1'b0;
		hwInt = 6'h3f;
		hwNext = 6'h3f;
		wdNext = '0;
		errCount = 0;
		testCount = 0;
		badTests = 0;
		repeat (8) @(posedge clk);
		rstN <= 1'b1;

		startTest("reset state");
		exec(32'h0, nop);
		noExc("nop at bubble");
		exec(32'h3000, cop0Word(`RsMfc0, `Cp0Sr));
		checkWord("SR", readData, 32'h0);
		// IP already shows the lines held through reset
		exec(32'h3004, cop0Word(`RsMfc0, `Cp0Cause));
		checkWord("Cause", readData, 32'h0000_FC00);
		exec(32'h3008, cop0Word(`RsMfc0, `Cp0Epc));
		checkWord("EPC", readData, 32'h0);
		exec(32'h300c, cop0Word(`RsMfc0, `Cp0Prid));
		checkWord("PRId", readData, `PRIdValue);
		endTest();

		startTest("address faults");
		faultCase("misaligned lw", 32'h3000, opWord(`OpLw), 32'h102, 1'b0, 1'b0, `ExcAdEL);
		faultCase("misaligned sh", 32'h3000, opWord(`OpSh), 32'h101, 1'b0, 1'b0, `ExcAdES);
		faultCase("lb to timer 0", 32'h3000, opWord(`OpLb), `Timer0First, 1'b0, 1'b0,
			`ExcAdEL);
		faultCase("sw outside map", 32'h3000, opWord(`OpSw), 32'h5000, 1'b0, 1'b0, `ExcAdES);
		faultCase("load overflow", 32'h3000, opWord(`OpLw), 32'h100, 1'b0, 1'b1, `ExcAdEL);
		faultCase("misaligned pc", 32'h3002, nop, 32'h0, 1'b0, 1'b0, `ExcAdEL);
		for (k = 0; k < 8; k++) begin
			// Word index inside the 0x3000 byte RAM
			ramAddr = randBits(12);
			if (ramAddr >= 32'h0000_0C00) begin
				ramAddr = ramAddr - 32'h0000_0400;
			end
			wdNext = randBits(32);
			step(32'h3000 + (k << 2), opWord(k[0] ? `OpSw : `OpLw), ramAddr << 2, 1'b0, 1'b0);
			noExc("random RAM access");
		end
		endTest();

		startTest("sync faults");
		faultCase("syscall", 32'h3000, specialWord(`FnSyscall), 32'h0, 1'b0, 1'b0, `ExcSys);
		faultCase("undefined opcode", 32'h3000, opWord(6'h3f), 32'h0, 1'b0, 1'b0, `ExcRI);
		faultCase("add overflow", 32'h3000, specialWord(`FnAdd), 32'h0, 1'b1, 1'b0, `ExcOv);
		step(32'h3004, opWord(`OpOri), 32'h0, 1'b1, 1'b0);
		noExc("ori overflow");
		faultCase("RI at odd pc", 32'h3001, opWord(6'h3f), 32'h0, 1'b0, 1'b0, `ExcAdEL);
		endTest();

		startTest("interrupt masking");
		hwNext = 6'h3f;
		wdNext = 32'h0000_0001;
		exec(32'h3000, cop0Word(`RsMtc0, `Cp0Sr));
		noExc("SR clear");
		wdNext = 32'h0000_FC00;
		exec(32'h3004, cop0Word(`RsMtc0, `Cp0Sr));
		noExc("IM clear");
		wdNext = 32'h0000_FC01;
		exec(32'h3008, cop0Word(`RsMtc0, `Cp0Sr));
		noExc("IE clear");
		exec(32'h3010, specialWord(`FnSyscall));
		checkExc("interrupt over syscall", 1'b1, `ExcInt);
		hwNext = 6'h00;
		wdNext = 32'h0;
		exec(32'h3014, cop0Word(`RsMtc0, `Cp0Sr));
		endTest();

		startTest("commit and eret");
		exec(32'h3020, specialWord(`FnSyscall));
		checkExc("syscall", 1'b1, `ExcSys);
		exec(32'h3024, nop);
		checkWord("EPC", epc, 32'h3020);
		exec(32'h3028, specialWord(`FnSyscall));
		noExc("fault with EXL set");
		exec(32'h302c, nop);
		checkWord("EPC kept", epc, 32'h3020);
		exec(32'h3030, eretWord);
		exec(32'h3034, specialWord(`FnSyscall));
		checkExc("fault after eret", 1'b1, `ExcSys);
		exec(32'h3038, eretWord);
		checkWord("EPC after eret", epc, 32'h3034);
		endTest();

		startTest("CP0 access");
		expWord = randBits(32);
		wdNext = expWord;
		exec(32'h3040, cop0Word(`RsMtc0, `Cp0Epc));
		exec(32'h3044, cop0Word(`RsMfc0, `Cp0Epc));
		checkWord("EPC round trip", readData, expWord);
		// IM only, IE and EXL stay clear
		expWord = randBits(6) << 10;
		wdNext = expWord;
		exec(32'h3048, cop0Word(`RsMtc0, `Cp0Sr));
		exec(32'h304c, cop0Word(`RsMfc0, `Cp0Sr));
		checkWord("SR round trip", readData, expWord);
		hwNext = 6'h15;
		exec(32'h3050, cop0Word(`RsMfc0, `Cp0Cause));
		checkWord("Cause.IP before edge", readData & 32'h0000_FC00, 32'h0);
		exec(32'h3054, cop0Word(`RsMfc0, `Cp0Cause));
		checkWord("Cause.IP", readData & 32'h0000_FC00, 32'h0000_5400);
		wdNext = 32'h1234_5678;
		exec(32'h3001, cop0Word(`RsMtc0, `Cp0Epc));
		checkExc("mtc0 at faulting pc", 1'b1, `ExcAdEL);
		exec(32'h3058, cop0Word(`RsMfc0, `Cp0Epc));
		checkWord("EPC after blocked mtc0", readData, 32'h3001);
		exec(32'h305c, eretWord);
		endTest();

		$display("summary: %0d tests, %0d with errors, %0d check errors, %0d assertion errors",
			testCount, badTests, errCount, dut0.chk0.failCount);
		if (errCount == 0 && dut0.chk0.failCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
mipsIsaPkg.sv
excPkg.sv
excCoder.sv
cp0Regs.sv
excUnit.sv
excUnit_assert.sv
tbExcUnit.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --assert -j 0
TOP      := tbExcUnit
FILELIST := sources.f

OBJDIR   := obj_dir
SIM      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
PASS     := all tests passed
SOURCES  := $(filter-out +incdir+%,$(shell cat $(FILELIST))) mips_params.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) +verilator+error+limit+100 2>&1 | tee $(LOG)
	grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
